/* common/cache_cfg_pkg.sv */
////////////////////////////////////////
// cache geometry
// sizes of the two-way instruction cache
// and the split of a core address
////////////////////////////////////////

`default_nettype none

package cache_cfg_pkg;

  ////////////////////////////////////////
  // core side
  localparam int XLEN = 32;

  ////////////////////////////////////////
  // organisation
  // two ways of sixteen sets
  localparam int WAYS = 2;
  localparam int SETS = 16;

  // one line holds two core words
  localparam int BLK_BITS      = 64;
  localparam int WORDS_PER_BLK = 2;

  ////////////////////////////////////////
  // address fields
  // byte offset inside a line
  localparam int BLK_OFFS_BITS = 3;
  // selects one of the sets
  localparam int IDX_BITS      = 4;
  // whatever is left of the address
  localparam int TAG_BITS      = 25;

endpackage

`default_nettype wire

/* common/cache_types_pkg.sv */
////////////////////////////////////////
// cache types
// stored tag, line, address split and
// controller states
////////////////////////////////////////

`default_nettype none

package cache_types_pkg;

  import cache_cfg_pkg::*;

  // tag as kept in the tag RAM
  typedef logic [TAG_BITS-1:0] tag_t;

  // one full line as delivered by the bus
  typedef logic [BLK_BITS-1:0] line_t;

  // core address seen as tag, set index and byte offset
  // fields add up to XLEN
  typedef struct packed {
    tag_t                     tag;
    logic [IDX_BITS-1:0]      idx;
    logic [BLK_OFFS_BITS-1:0] offs;
  } addr_fields_t;

  // controller FSM
  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    CHECK,
    FILL_REQ,
    FILL_WAIT,
    RESPOND
  } ctrl_state_t;

endpackage

`default_nettype wire

/* common/cache_mem_if.sv */
////////////////////////////////////////
// controller to cache memory link
// lookup, fill and flush controls going
// down, hit and line coming back
////////////////////////////////////////

`default_nettype none

interface cache_mem_if;

  import cache_cfg_pkg::*;
  import cache_types_pkg::*;

  // lookup side
  logic [IDX_BITS-1:0] rd_idx;
  tag_t                rd_tag;

  // fill side, index and way are held by the memory
  logic [IDX_BITS-1:0] wr_idx;
  tag_t                wr_tag;
  logic                filling;
  // one cycle, bus line arrives
  logic                fill_ack;
  logic [WAYS-1:0]     fill_way;
  line_t               fill_line;

  // clears all valid bits
  logic                flushing;

  // registered lookup result
  logic                hit;
  line_t               line;

  modport ctrl_mp (
    output rd_idx, rd_tag, wr_idx, wr_tag, filling, fill_ack,
    output fill_way, fill_line, flushing,
    input  hit, line
  );

  modport mem_mp (
    input  rd_idx, rd_tag, wr_idx, wr_tag, filling, fill_ack,
    input  fill_way, fill_line, flushing,
    output hit, line
  );

endinterface

`default_nettype wire

/* src/ram_1rw.sv */
////////////////////////////////////////
// generic single-port RAM
// registered read, write-first, one
// entry per cache set
////////////////////////////////////////

`default_nettype none

module ram_1rw #(
  parameter type word_t = logic [31:0],
  // one entry per set
  localparam int DEPTH = 2 ** cache_cfg_pkg::IDX_BITS
) (
  input  logic                               clk_i,
  input  logic [cache_cfg_pkg::IDX_BITS-1:0] addr_i,
  input  logic                               we_i,
  input  word_t                              din_i,
  output word_t                              dout_o
);

  // storage array
  word_t mem_q [DEPTH];

  // write port
  always_ff @(posedge clk_i)
  begin
    if (we_i)
      mem_q[addr_i] <= din_i;
  end

  // read port, new data shows up
  // on the output when written
  always_ff @(posedge clk_i)
  begin
    if (we_i)
      dout_o <= din_i;
    else
      dout_o <= mem_q[addr_i];
  end

endmodule

`default_nettype wire

/* cache_memory/cache_memory.sv */
////////////////////////////////////////
// cache memory
// tag and data RAMs per way, valid bits,
// fill bypass and registered hit/line
////////////////////////////////////////

`default_nettype none

module cache_memory (
  input  logic        clk_i,
  input  logic        rst_ni,
  cache_mem_if.mem_mp mem
);

  import cache_cfg_pkg::*;
  import cache_types_pkg::*;

  ////////////////////////////////////////
  // signals

  // fill write strobe and its delayed copy
  logic                fill_we;
  logic                fill_we_dly;
  // fill index and way, held while filling
  logic [IDX_BITS-1:0] fill_idx_q;
  logic [WAYS-1:0]     fill_way_q;

  // shared RAM index and lookup index delayed like the RAM
  logic [IDX_BITS-1:0] ram_idx;
  logic [IDX_BITS-1:0] idx_dly;

  tag_t                tag_out [WAYS];
  line_t               dat_out [WAYS];
  line_t               way_mux [WAYS];
  logic [WAYS-1:0]     way_we;
  logic [WAYS-1:0]     way_hit;
  logic [SETS-1:0]     valid_q [WAYS];

  // bypass copy of the last written line
  tag_t                byp_tag;
  logic [IDX_BITS-1:0] byp_idx;
  line_t               byp_line;
  logic                byp_valid;
  logic                byp_hit;

  ////////////////////////////////////////
  // fill control

  assign fill_we = mem.filling & mem.fill_ack;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      fill_we_dly <= 1'b0;
    else
      fill_we_dly <= fill_we;
  end

  // index and way frozen once the fill starts
  always_ff @(posedge clk_i)
  begin
    if (!mem.filling)
    begin
      fill_idx_q <= mem.wr_idx;
      fill_way_q <= mem.fill_way;
    end
  end

  // fill owns the RAM port on its ack cycle
  assign ram_idx = fill_we ? fill_idx_q : mem.rd_idx;

  // same delay as through the RAM
  always_ff @(posedge clk_i)
  begin
    idx_dly <= mem.rd_idx;
  end

  ////////////////////////////////////////
  // bypass register

  // covers a lookup right behind a fill
  always_ff @(posedge clk_i)
  begin
    if (fill_we)
    begin
      byp_tag  <= mem.wr_tag;
      byp_idx  <= fill_idx_q;
      byp_line <= mem.fill_line;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      byp_valid <= 1'b0;
    else if (mem.flushing)
      byp_valid <= 1'b0;
    else if (fill_we)
      byp_valid <= 1'b1;
  end

  assign byp_hit = byp_valid & (idx_dly == byp_idx) & (mem.rd_tag == byp_tag);

  ////////////////////////////////////////
  // ways

  for (genvar w = 0; w < WAYS; w++)
  begin : gen_way
    assign way_we[w] = fill_we & fill_way_q[w];

    ram_1rw #(
      .word_t (tag_t)
    ) u_tag_ram (
      .clk_i  (clk_i),
      .addr_i (ram_idx),
      .we_i   (way_we[w]),
      .din_i  (mem.wr_tag),
      .dout_o (tag_out[w])
    );

    ram_1rw #(
      .word_t (line_t)
    ) u_dat_ram (
      .clk_i  (clk_i),
      .addr_i (ram_idx),
      .we_i   (way_we[w]),
      .din_i  (mem.fill_line),
      .dout_o (dat_out[w])
    );

    // valid bits live in flops so a flush takes one cycle
    always_ff @(posedge clk_i or negedge rst_ni)
    begin
      if (!rst_ni)
        valid_q[w] <= '0;
      else if (mem.flushing)
        valid_q[w] <= '0;
      else if (way_we[w])
        valid_q[w][fill_idx_q] <= 1'b1;
    end

    // tag compare in the cycle after the read
    assign way_hit[w] = valid_q[w][idx_dly] & (tag_out[w] == mem.rd_tag);

    // AND/OR way mux
    if (w == 0)
    begin : gen_mux_first
      assign way_mux[w] = dat_out[w] & {BLK_BITS{way_hit[w]}};
    end
    else
    begin : gen_mux_rest
      assign way_mux[w] = (dat_out[w] & {BLK_BITS{way_hit[w]}}) | way_mux[w-1];
    end
  end

  ////////////////////////////////////////
  // registered result

  // RAM output after a fill cycle belongs to the fill index
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      mem.hit <= 1'b0;
    else
      mem.hit <= byp_hit | ((|way_hit) & ~fill_we_dly);
  end

  always_ff @(posedge clk_i)
  begin
    mem.line <= byp_hit ? byp_line : way_mux[WAYS-1];
  end

  // a tag is only ever filled into one way of a set
  a_one_way_hit : assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(way_hit));

endmodule

`default_nettype wire

/* src/cache_ctrl.sv */
////////////////////////////////////////
// cache controller
// request handshake, lookup, line fill,
// round-robin victim, flush, word select
////////////////////////////////////////

`default_nettype none

module cache_ctrl (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            req_valid_i,
  output logic                            req_ready_o,
  input  logic [cache_cfg_pkg::XLEN-1:0]  req_addr_i,
  output logic                            rsp_valid_o,
  input  logic                            rsp_ready_i,
  output logic [cache_cfg_pkg::XLEN-1:0]  rsp_data_o,
  output logic                            rsp_miss_o,
  output logic                            bus_req_valid_o,
  input  logic                            bus_req_ready_i,
  output logic [cache_cfg_pkg::XLEN-1:0]  bus_req_addr_o,
  input  logic                            bus_rsp_valid_i,
  input  cache_types_pkg::line_t          bus_rsp_data_i,
  input  logic                            flush_i,
  cache_mem_if.ctrl_mp                    mem
);

  import cache_cfg_pkg::*;
  import cache_types_pkg::*;

  localparam int WSEL_BITS = $clog2(WORDS_PER_BLK);
  localparam int VICT_BITS = $clog2(WAYS);

  ctrl_state_t            state_q;
  addr_fields_t           req_fields;
  addr_fields_t           addr_q;
  logic                   flushing_q;
  logic                   miss_q;
  logic [XLEN-1:0]        data_q;
  logic [VICT_BITS-1:0]   victim_q;
  logic [WSEL_BITS-1:0]   wsel;

  assign req_fields = req_addr_i;
  // word within the line
  assign wsel = addr_q.offs[BLK_OFFS_BITS-1 -: WSEL_BITS];

  ////////////////////////////////////////
  // handshakes

  // no accept while a flush is pending or running
  assign req_ready_o     = (state_q == IDLE) & ~flushing_q & ~flush_i;
  assign rsp_valid_o     = (state_q == RESPOND);
  assign rsp_data_o      = data_q;
  assign rsp_miss_o      = miss_q;
  assign bus_req_valid_o = (state_q == FILL_REQ);
  assign bus_req_addr_o  = {addr_q.tag, addr_q.idx, {BLK_OFFS_BITS{1'b0}}};

  ////////////////////////////////////////
  // memory controls

  // idle reads straight from the core so the hit is ready in CHECK
  assign mem.rd_idx    = (state_q == IDLE) ? req_fields.idx : addr_q.idx;
  assign mem.rd_tag    = addr_q.tag;
  assign mem.wr_idx    = addr_q.idx;
  assign mem.wr_tag    = addr_q.tag;
  assign mem.filling   = (state_q == FILL_REQ) | (state_q == FILL_WAIT);
  assign mem.fill_ack  = (state_q == FILL_WAIT) & bus_rsp_valid_i;
  assign mem.fill_way  = WAYS'(1) << victim_q;
  assign mem.fill_line = bus_rsp_data_i;
  assign mem.flushing  = flushing_q;

  ////////////////////////////////////////
  // FSM

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state_q    <= IDLE;
      flushing_q <= 1'b0;
      miss_q     <= 1'b0;
      victim_q   <= '0;
    end
    else
    begin
      // flush lasts exactly one cycle
      flushing_q <= (state_q == IDLE) & flush_i & ~flushing_q;
      case (state_q)
        IDLE:
          if (req_valid_i && req_ready_o)
          begin
            state_q <= LOOKUP;
            miss_q  <= 1'b0;
          end
        LOOKUP:
          state_q <= CHECK;
        CHECK:
          if (mem.hit)
            state_q <= RESPOND;
          else
          begin
            state_q <= FILL_REQ;
            miss_q  <= 1'b1;
          end
        FILL_REQ:
          if (bus_req_ready_i)
            state_q <= FILL_WAIT;
        FILL_WAIT:
          if (bus_rsp_valid_i)
          begin
            // replay the lookup, bypass gives the new line
            state_q <= LOOKUP;
            if (victim_q == VICT_BITS'(WAYS - 1))
              victim_q <= '0;
            else
              victim_q <= victim_q + 1'b1;
          end
        RESPOND:
          if (rsp_ready_i)
            state_q <= IDLE;
        default:
          state_q <= IDLE;
      endcase
    end
  end

  // request address and response word
  always_ff @(posedge clk_i)
  begin
    if (req_valid_i && req_ready_o)
      addr_q <= req_fields;
    if (state_q == CHECK && mem.hit)
      data_q <= mem.line[int'(wsel)*XLEN +: XLEN];
  end

  a_bus_req_hold : assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_req_valid_o && !bus_req_ready_i |=> bus_req_valid_o && $stable(bus_req_addr_o));

  // the lookup replayed after a fill must find the new line
  a_replay_hits : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q == CHECK) && miss_q |-> mem.hit);

endmodule

`default_nettype wire

/* src/cache_top.sv */
////////////////////////////////////////
// instruction cache top
// controller and memory joined by the
// cache memory interface
////////////////////////////////////////

`default_nettype none

module cache_top (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  // core request
  input  logic                            req_valid_i,
  output logic                            req_ready_o,
  input  logic [cache_cfg_pkg::XLEN-1:0]  req_addr_i,
  // core response
  output logic                            rsp_valid_o,
  input  logic                            rsp_ready_i,
  output logic [cache_cfg_pkg::XLEN-1:0]  rsp_data_o,
  output logic                            rsp_miss_o,
  // bus request, line aligned
  output logic                            bus_req_valid_o,
  input  logic                            bus_req_ready_i,
  output logic [cache_cfg_pkg::XLEN-1:0]  bus_req_addr_o,
  // bus response, always accepted
  input  logic                            bus_rsp_valid_i,
  input  cache_types_pkg::line_t          bus_rsp_data_i,
  // flush all lines
  input  logic                            flush_i
);

  cache_mem_if mem_if ();

  cache_ctrl u_ctrl (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_valid_i     (req_valid_i),
    .req_ready_o     (req_ready_o),
    .req_addr_i      (req_addr_i),
    .rsp_valid_o     (rsp_valid_o),
    .rsp_ready_i     (rsp_ready_i),
    .rsp_data_o      (rsp_data_o),
    .rsp_miss_o      (rsp_miss_o),
    .bus_req_valid_o (bus_req_valid_o),
    .bus_req_ready_i (bus_req_ready_i),
    .bus_req_addr_o  (bus_req_addr_o),
    .bus_rsp_valid_i (bus_rsp_valid_i),
    .bus_rsp_data_i  (bus_rsp_data_i),
    .flush_i         (flush_i),
    .mem             (mem_if.ctrl_mp)
  );

  cache_memory u_mem (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .mem    (mem_if.mem_mp)
  );

endmodule

`default_nettype wire

/* sim/cache_tb.sv */
////////////////////////////////////////
// cache testbench
// replays the pattern list, models the
// backing bus and checks every response
////////////////////////////////////////

`default_nettype none

module cache_tb;

  import cache_cfg_pkg::*;
  import cache_types_pkg::*;

  localparam int          MAX_ENTRIES = 64;
  localparam int          TIMEOUT     = 200;
  localparam int          STALL       = 5;
  localparam logic [31:0] SEED        = 32'd19566;
  // operation codes of the pattern list
  localparam logic [31:0] OP_READ  = 32'h0;
  localparam logic [31:0] OP_STALL = 32'h1;
  localparam logic [31:0] OP_FLUSH = 32'h2;
  localparam logic [31:0] OP_END   = 32'hf;

  logic            clk_i;
  logic            rst_ni;
  logic            req_valid_i;
  logic            req_ready_o;
  logic [XLEN-1:0] req_addr_i;
  logic            rsp_valid_o;
  logic            rsp_ready_i;
  logic [XLEN-1:0] rsp_data_o;
  logic            rsp_miss_o;
  logic            bus_req_valid_o;
  logic            bus_req_ready_i;
  logic [XLEN-1:0] bus_req_addr_o;
  logic            bus_rsp_valid_i;
  line_t           bus_rsp_data_i;
  logic            flush_i;

  // four words per entry
  logic [31:0] patterns [4*MAX_ENTRIES];
  logic [31:0] lcg_state;
  int          mismatches;
  int          failures;
  int          entries;
  bit          hung;

  cache_top u_dut (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_valid_i     (req_valid_i),
    .req_ready_o     (req_ready_o),
    .req_addr_i      (req_addr_i),
    .rsp_valid_o     (rsp_valid_o),
    .rsp_ready_i     (rsp_ready_i),
    .rsp_data_o      (rsp_data_o),
    .rsp_miss_o      (rsp_miss_o),
    .bus_req_valid_o (bus_req_valid_o),
    .bus_req_ready_i (bus_req_ready_i),
    .bus_req_addr_o  (bus_req_addr_o),
    .bus_rsp_valid_i (bus_rsp_valid_i),
    .bus_rsp_data_i  (bus_rsp_data_i),
    .flush_i         (flush_i)
  );

  initial clk_i = 1'b0;
  always #5 clk_i = ~clk_i;

  ////////////////////////////////////////
  // backing memory model

  function automatic logic [31:0] lcg_next(input logic [31:0] x);
    return x * 32'd69069 + 32'd1;
  endfunction

  // every word address gets its own hashed value
  function automatic logic [31:0] mem_word(input logic [31:0] waddr);
    return lcg_next(SEED + waddr);
  endfunction

  // inputs change just after the rising edge
  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  // entered at the negedge that shows the bus request
  task automatic serve_fill(input logic [31:0] line_addr);
    int          delay;
    logic [31:0] waddr;
    waddr     = line_addr >> 2;
    lcg_state = lcg_next(lcg_state);
    delay     = 1 + int'(lcg_state[17:16]);
    // request taken on this edge
    next_cycle();
    repeat (delay - 1) next_cycle();
    // word 0 sits in the low half of the line
    bus_rsp_valid_i = 1'b1;
    bus_rsp_data_i  = {mem_word(waddr + 32'd1), mem_word(waddr)};
    next_cycle();
    bus_rsp_valid_i = 1'b0;
  endtask

  ////////////////////////////////////////
  // operations

  task automatic run_read(input logic [31:0] addr, input logic [31:0] exp_word,
                          input logic exp_miss, input bit stall);
    int          cycles;
    int          latency;
    int          bus_reqs;
    logic [31:0] held;
    bit          done;
    cycles      = 0;
    latency     = 0;
    bus_reqs    = 0;
    done        = 1'b0;
    req_valid_i = 1'b1;
    req_addr_i  = addr;
    rsp_ready_i = !stall;
    @(negedge clk_i);
    while (!req_ready_o && cycles < TIMEOUT)
    begin
      cycles++;
      @(negedge clk_i);
    end
    if (!req_ready_o)
    begin
      failures++;
      hung = 1'b1;
      $display("request for address %h was never accepted", addr);
      return;
    end
    // taken on the next edge, a stalled read keeps another request waiting
    next_cycle();
    req_valid_i = stall;
    req_addr_i  = addr ^ 32'h80;
    while (!done && latency < TIMEOUT)
    begin
      @(negedge clk_i);
      latency++;
      if (rsp_valid_o)
        done = 1'b1;
      else if (bus_req_valid_o)
      begin
        bus_reqs++;
        if (bus_req_addr_o !== {addr[31:3], 3'b000})
        begin
          mismatches++;
          $display("Mismatch bus_req_addr_o: got %h, expected %h",
                   bus_req_addr_o, {addr[31:3], 3'b000});
        end
        serve_fill(bus_req_addr_o);
      end
    end
    if (!done)
    begin
      failures++;
      hung = 1'b1;
      $display("no response for address %h", addr);
      return;
    end
    if (rsp_data_o !== exp_word)
    begin
      mismatches++;
      $display("Mismatch rsp_data_o for address %h: got %h, expected %h",
               addr, rsp_data_o, exp_word);
    end
    if (rsp_miss_o !== exp_miss)
    begin
      mismatches++;
      $display("Mismatch rsp_miss_o for address %h: got %h, expected %h",
               addr, rsp_miss_o, exp_miss);
    end
    if (bus_reqs != int'(exp_miss))
    begin
      failures++;
      $display("address %h issued %0d bus requests", addr, bus_reqs);
    end
    // hit path is fixed: lookup, check, respond
    if (!exp_miss && latency != 3)
    begin
      failures++;
      $display("hit on address %h answered after %0d cycles instead of 3", addr, latency);
    end
    if (stall)
    begin
      held = rsp_data_o;
      repeat (STALL)
      begin
        @(negedge clk_i);
        if (!rsp_valid_o)
        begin
          failures++;
          $display("rsp_valid_o dropped while rsp_ready_i was low");
        end
        if (rsp_data_o !== held)
        begin
          mismatches++;
          $display("Mismatch rsp_data_o under stall: got %h, expected %h", rsp_data_o, held);
        end
        if (req_ready_o)
        begin
          failures++;
          $display("new request could be accepted during a stalled response");
        end
      end
      next_cycle();
      rsp_ready_i = 1'b1;
      @(negedge clk_i);
    end
    // response taken on this edge
    next_cycle();
    req_valid_i = 1'b0;
  endtask

  task automatic run_flush();
    flush_i = 1'b1;
    @(negedge clk_i);
    if (req_ready_o)
    begin
      failures++;
      $display("req_ready_o high while a flush was requested");
    end
    next_cycle();
    flush_i = 1'b0;
    @(negedge clk_i);
    if (req_ready_o)
    begin
      failures++;
      $display("req_ready_o high during the flush cycle");
    end
    next_cycle();
  endtask

  ////////////////////////////////////////
  // main sequence

  initial
  begin
    int idx;
    rst_ni          = 1'b0;
    req_valid_i     = 1'b0;
    req_addr_i      = '0;
    rsp_ready_i     = 1'b1;
    bus_req_ready_i = 1'b1;
    bus_rsp_valid_i = 1'b0;
    bus_rsp_data_i  = '0;
    flush_i         = 1'b0;
    lcg_state       = SEED;
    mismatches      = 0;
    failures        = 0;
    entries         = 0;
    hung            = 1'b0;
    // a missing file leaves only end markers
    for (int i = 0; i < 4 * MAX_ENTRIES; i++)
      patterns[i] = OP_END;
    $readmemh("sim/cache_patterns.hex", patterns);
    repeat (2) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    @(negedge clk_i);
    if (!req_ready_o || rsp_valid_o || bus_req_valid_o)
    begin
      failures++;
      $display("handshake outputs wrong after reset");
    end
    next_cycle();
    idx = 0;
    while (idx < MAX_ENTRIES && !hung && patterns[4*idx] != OP_END)
    begin
      case (patterns[4*idx])
        OP_READ:
          run_read(patterns[4*idx+1], patterns[4*idx+2], patterns[4*idx+3][0], 1'b0);
        OP_STALL:
          run_read(patterns[4*idx+1], patterns[4*idx+2], patterns[4*idx+3][0], 1'b1);
        OP_FLUSH:
          run_flush();
        default:
        begin
          failures++;
          $display("unknown operation %h in entry %0d", patterns[4*idx], idx);
        end
      endcase
      entries++;
      idx++;
    end
    if (entries == 0)
    begin
      failures++;
      $display("pattern list held no entries");
    end
    $display("entries %0d, mismatches %0d, other errors %0d", entries, mismatches, failures);
    if (mismatches == 0 && failures == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

/* sim/cache_patterns.hex */
// op (0 read, 1 read with stalled response, 2 flush, f end), byte address,
// expected rsp_data_o, expected rsp_miss_o
0 0000020C 5116D9FE 1
0 0000020C 5116D9FE 0
0 00000208 5115CC31 0
0 00000010 5091014B 1
0 00000094 50B3C8B8 1
0 00000110 50D4748B 1
0 00000014 50920F18 1
0 00000114 50D58258 0
0 00000090 50B2BAEB 1
0 00000094 50B3C8B8 0
1 0000020C 5116D9FE 0
2 00000000 00000000 0
0 00000208 5115CC31 1
0 00000110 50D4748B 1
0 00000014 50920F18 1
0 00000014 50920F18 0
1 00000090 50B2BAEB 1
0 00000110 50D4748B 1
F 00000000 00000000 0

/* sim.f */
common/cache_cfg_pkg.sv
common/cache_types_pkg.sv
common/cache_mem_if.sv
src/ram_1rw.sv
cache_memory/cache_memory.sv
src/cache_ctrl.sv
src/cache_top.sv
sim/cache_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the cache testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module cache_tb -o cache_tb_sim \
  && ./obj_dir/cache_tb_sim | tee /dev/stderr | grep -x "Verification passed" > /dev/null \
  || { echo "simulation run did not pass" >&2; exit 1; }

exit 0
